// File: include/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Datapath width of operands and results
`define WB_XLEN 32

// Tags in flight, keep a power of two so tag counters wrap cleanly
`define WB_MAX_INFLIGHT 4

// Execution units on the write-back side
`define WB_NUM_UNITS 2

// Pipeline depth per unit
`define WB_MUL_LATENCY 4
`define WB_ALU_LATENCY 1

`endif

// File: hw/core_id_pkg.sv
`include "wb_settings.svh"

package core_id_pkg;

    ////////////////////////////////////////
    // Instruction tags

    // One tag per in-flight instruction
    typedef logic [$clog2(`WB_MAX_INFLIGHT)-1:0] instr_id_t;

    ////////////////////////////////////////
    // Per-tag bookkeeping

    // Held in the packet table from issue until retire
    typedef struct packed {
        logic [4:0] rd_addr;
        // Destination is not x0
        logic       rd_nzero;
        // Retires without a register write
        logic       no_rd;
    } inflight_packet_t;

    ////////////////////////////////////////
    // Register file commit

    // One retired result, in issue order
    typedef struct packed {
        logic                commit;
        logic [4:0]          rd_addr;
        logic                rd_nzero;
        instr_id_t           id;
        logic [`WB_XLEN-1:0] rd_data;
    } rf_commit_t;

endpackage

// File: hw/exec_pkg.sv
`include "wb_settings.svh"

package exec_pkg;

    ////////////////////////////////////////
    // Operations

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } op_t;

    // Unit index, also the slot in the write-back array
    typedef enum logic [$clog2(`WB_NUM_UNITS)-1:0] {
        UNIT_ALU = 0,
        UNIT_MUL = 1
    } unit_sel_t;

    ////////////////////////////////////////
    // Issue port payload

    // Wishbone write data
    typedef struct packed {
        op_t                 op;
        logic [`WB_XLEN-1:0] operand_a;
        logic [`WB_XLEN-1:0] operand_b;
        logic [4:0]          rd_addr;
        logic                no_rd;
    } issue_req_t;

    // Tagged request into one unit
    typedef struct packed {
        logic                  valid;
        core_id_pkg::instr_id_t id;
        op_t                   op;
        logic [`WB_XLEN-1:0]   operand_a;
        logic [`WB_XLEN-1:0]   operand_b;
    } unit_req_t;

    // Unit result, tag and rd valid while done_next_cycle is high
    typedef struct packed {
        logic                  done_next_cycle;
        core_id_pkg::instr_id_t id;
        logic [`WB_XLEN-1:0]   rd;
    } unit_wb_t;

endpackage

// File: hw/id_tracking.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module id_tracking (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issued,
    input  logic                   retired,
    output core_id_pkg::instr_id_t next_id,
    output core_id_pkg::instr_id_t oldest_id,
    output logic                   id_available,
    output logic                   empty
);

    // Occupancy needs one extra bit to hold the full count
    logic [$clog2(`WB_MAX_INFLIGHT+1)-1:0] inflight_count;

    ////////////////////////////////////////
    // Tag counters

    // Both pointers wrap with the tag width
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id   <= '0;
            oldest_id <= '0;
        end else begin
            if (issued)
                next_id <= next_id + 1'b1;
            if (retired)
                oldest_id <= oldest_id + 1'b1;
        end
    end

    // Outstanding tag count
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({issued, retired})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Full when every tag is outstanding
    assign id_available = (inflight_count != `WB_MAX_INFLIGHT);
    assign empty        = (inflight_count == '0);

    ////////////////////////////////////////
    // Checks

    // Write-back only retires tags that were handed out
    retire_when_empty: assert property (@(posedge clk) disable iff (rst)
        !(retired && empty));

    // Issue side must hold off while the tracker is full
    issue_when_full: assert property (@(posedge clk) disable iff (rst)
        issued |-> id_available);

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module exec_unit #(
    parameter int LATENCY = 1,
    parameter bit HAS_MUL = 1'b0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  exec_pkg::unit_req_t  req,
    output exec_pkg::unit_wb_t   wb
);

    // Result computed at entry, then carried down the pipe
    logic [`WB_XLEN-1:0] result;
    // Low word only, upper half is dropped by the width
    logic [`WB_XLEN-1:0] product;

    // Stage LATENCY-1 is the output stage
    exec_pkg::unit_wb_t stage [LATENCY-1:0];

    ////////////////////////////////////////
    // Operation select

    assign product = req.operand_a * req.operand_b;

    always_comb begin
        case (req.op)
            exec_pkg::OP_ADD: result = req.operand_a + req.operand_b;
            exec_pkg::OP_SUB: result = req.operand_a - req.operand_b;
            exec_pkg::OP_XOR: result = req.operand_a ^ req.operand_b;
            // Only meaningful in the multiplier build
            exec_pkg::OP_MUL: result = HAS_MUL ? product : '0;
            default:          result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Shift pipeline

    // One new op may enter every cycle
    always_ff @(posedge clk) begin
        // Tag and data move without reset
        stage[0].id <= req.id;
        stage[0].rd <= result;
        for (int i = 1; i < LATENCY; i++) begin
            stage[i].id <= stage[i-1].id;
            stage[i].rd <= stage[i-1].rd;
        end

        // Valid bits
        if (rst) begin
            for (int i = 0; i < LATENCY; i++)
                stage[i].done_next_cycle <= 1'b0;
        end else begin
            stage[0].done_next_cycle <= req.valid;
            for (int i = 1; i < LATENCY; i++)
                stage[i].done_next_cycle <= stage[i-1].done_next_cycle;
        end
    end

    // Last stage faces write-back
    assign wb = stage[LATENCY-1];

    ////////////////////////////////////////
    // Checks

    // Dispatch in the top must steer multiplies elsewhere
    mul_on_alu: assert property (@(posedge clk) disable iff (rst)
        !(req.valid && (req.op == exec_pkg::OP_MUL) && !HAS_MUL));

endmodule

// File: hw/write_back.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module write_back (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issued,
    input  core_id_pkg::inflight_packet_t issue_packet,
    input  exec_pkg::unit_wb_t            unit_wb [`WB_NUM_UNITS],
    output core_id_pkg::rf_commit_t       commit,
    output core_id_pkg::instr_id_t        issue_id,
    output logic                          id_available,
    output logic                          queue_empty
);

    // In-flight packet per tag
    core_id_pkg::inflight_packet_t packet_table [`WB_MAX_INFLIGHT];

    // Result store, one word per tag
    logic [`WB_XLEN-1:0] rds_by_id [`WB_MAX_INFLIGHT];
    // Which unit delivers each tag this cycle
    exec_pkg::unit_sel_t id_unit_select [`WB_MAX_INFLIGHT];

    logic [`WB_MAX_INFLIGHT-1:0] id_done_new;
    logic [`WB_MAX_INFLIGHT-1:0] id_done;
    logic [`WB_MAX_INFLIGHT-1:0] id_done_r;
    logic [`WB_MAX_INFLIGHT-1:0] id_retired;
    logic [`WB_MAX_INFLIGHT-1:0] id_retired_r;

    core_id_pkg::instr_id_t        oldest_id;
    core_id_pkg::instr_id_t        retired_id_r;
    core_id_pkg::inflight_packet_t retired_packet;
    logic                          retired;
    logic                          retired_r;
    // Two units on one tag, checked below
    logic                          unit_tag_clash;

    ////////////////////////////////////////
    // Result collection

    // Match each finishing unit against every tag
    always_comb begin
        for (int i = 0; i < `WB_MAX_INFLIGHT; i++) begin
            id_done_new[i]    = 1'b0;
            id_unit_select[i] = exec_pkg::UNIT_ALU;
            for (int j = 0; j < `WB_NUM_UNITS; j++) begin
                if (unit_wb[j].done_next_cycle &&
                    (unit_wb[j].id == core_id_pkg::instr_id_t'(i))) begin
                    id_unit_select[i] = exec_pkg::unit_sel_t'(j);
                    id_done_new[i]    = 1'b1;
                end
            end
        end
    end

    // Capture the delivered word at the next edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WB_MAX_INFLIGHT; i++) begin
            if (id_done_new[i])
                rds_by_id[i] <= unit_wb[id_unit_select[i]].rd;
        end
    end

    ////////////////////////////////////////
    // Tag tracking and packet table

    id_tracking id_tracker (
        .clk          (clk),
        .rst          (rst),
        .issued       (issued),
        .retired      (retired),
        .next_id      (issue_id),
        .oldest_id    (oldest_id),
        .id_available (id_available),
        .empty        (queue_empty)
    );

    // Written once per accepted instruction
    always_ff @(posedge clk) begin
        if (issued)
            packet_table[issue_id] <= issue_packet;
    end

    ////////////////////////////////////////
    // Done bits and retirement

    // One-hot of the tag leaving this cycle
    always_comb begin
        id_retired            = '0;
        id_retired[oldest_id] = retired;
    end

    // Bit of last cycle's retiree drops now
    assign id_done = (id_done_r & ~id_retired_r) | id_done_new;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_done_r    <= '0;
            id_retired_r <= '0;
            retired_r    <= 1'b0;
        end else begin
            id_done_r    <= id_done;
            id_retired_r <= id_retired;
            retired_r    <= retired;
        end
    end

    // Strict issue order, oldest tag only
    assign retired = id_done[oldest_id];

    always_ff @(posedge clk) begin
        retired_id_r <= oldest_id;
    end

    ////////////////////////////////////////
    // Commit

    assign retired_packet = packet_table[retired_id_r];

    // no_rd still frees its tag but stays off the commit stream
    assign commit.commit   = retired_r & ~retired_packet.no_rd;
    assign commit.rd_addr  = retired_packet.rd_addr;
    assign commit.rd_nzero = retired_packet.rd_nzero;
    assign commit.id       = retired_id_r;
    assign commit.rd_data  = rds_by_id[retired_id_r];

    ////////////////////////////////////////
    // Checks

    always_comb begin
        unit_tag_clash = 1'b0;
        for (int j = 0; j < `WB_NUM_UNITS; j++) begin
            for (int k = j + 1; k < `WB_NUM_UNITS; k++) begin
                unit_tag_clash |= unit_wb[j].done_next_cycle &
                                  unit_wb[k].done_next_cycle &
                                  (unit_wb[j].id == unit_wb[k].id);
            end
        end
    end

    // A tag lives in exactly one unit
    tag_in_two_units: assert property (@(posedge clk) disable iff (rst)
        !unit_tag_clash);

    // Tag reuse only after its done bit is cleared
    done_twice: assert property (@(posedge clk) disable iff (rst)
        (id_done_new & id_done_r & ~id_retired_r) == '0);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  core_id_pkg::rf_commit_t commit,
    input  logic [4:0]              rd_addr_port,
    output logic [`WB_XLEN-1:0]     rd_data_port
);

    // Architectural state
    logic [`WB_XLEN-1:0] regs [32];

    ////////////////////////////////////////
    // Write port

    // rd_nzero keeps x0 out of the write path
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (commit.commit && commit.rd_nzero) begin
            regs[commit.rd_addr] <= commit.rd_data;
        end
    end

    ////////////////////////////////////////
    // Read port

    // Asynchronous, x0 reads as zero
    assign rd_data_port = (rd_addr_port == 5'd0) ? '0 : regs[rd_addr_port];

    ////////////////////////////////////////
    // Checks

    // rd_nzero comes from the issue side and must agree with rd_addr
    nzero_flag: assert property (@(posedge clk) disable iff (rst)
        commit.commit |-> (commit.rd_nzero == (commit.rd_addr != 5'd0)));

endmodule

// File: hw/wb_backend_top.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_backend_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  exec_pkg::issue_req_t    wb_dat,
    input  logic [4:0]              reg_addr,
    output logic                    wb_ack,
    output core_id_pkg::rf_commit_t commit,
    output logic [`WB_XLEN-1:0]     reg_data,
    output logic                    busy
);

    logic                          issued;
    logic                          id_available;
    logic                          queue_empty;
    core_id_pkg::instr_id_t        issue_id;
    core_id_pkg::inflight_packet_t issue_packet;
    exec_pkg::unit_sel_t           unit_sel;

    exec_pkg::unit_req_t unit_req [`WB_NUM_UNITS];
    exec_pkg::unit_wb_t  unit_wb  [`WB_NUM_UNITS];

    ////////////////////////////////////////
    // Wishbone issue slave

    // Single-cycle ack, never back to back
    // Writes also wait for a free tag
    always_ff @(posedge clk) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc & wb_stb & ~wb_ack & (~wb_we | id_available);
    end

    // Master still holds data in the ack cycle
    assign issued = wb_ack & wb_we;

    assign issue_packet.rd_addr  = wb_dat.rd_addr;
    assign issue_packet.rd_nzero = |wb_dat.rd_addr;
    assign issue_packet.no_rd    = wb_dat.no_rd;

    ////////////////////////////////////////
    // Dispatch

    // Multiplies to the multiplier, the rest to the ALU
    assign unit_sel = (wb_dat.op == exec_pkg::OP_MUL) ? exec_pkg::UNIT_MUL
                                                      : exec_pkg::UNIT_ALU;

    always_comb begin
        for (int u = 0; u < `WB_NUM_UNITS; u++) begin
            unit_req[u].valid     = issued && (unit_sel == exec_pkg::unit_sel_t'(u));
            unit_req[u].id        = issue_id;
            unit_req[u].op        = wb_dat.op;
            unit_req[u].operand_a = wb_dat.operand_a;
            unit_req[u].operand_b = wb_dat.operand_b;
        end
    end

    exec_unit #(
        .LATENCY (`WB_ALU_LATENCY),
        .HAS_MUL (1'b0)
    ) alu_unit (
        .clk (clk),
        .rst (rst),
        .req (unit_req[exec_pkg::UNIT_ALU]),
        .wb  (unit_wb[exec_pkg::UNIT_ALU])
    );

    exec_unit #(
        .LATENCY (`WB_MUL_LATENCY),
        .HAS_MUL (1'b1)
    ) mul_unit (
        .clk (clk),
        .rst (rst),
        .req (unit_req[exec_pkg::UNIT_MUL]),
        .wb  (unit_wb[exec_pkg::UNIT_MUL])
    );

    ////////////////////////////////////////
    // Completion and state

    write_back write_back_inst (
        .clk          (clk),
        .rst          (rst),
        .issued       (issued),
        .issue_packet (issue_packet),
        .unit_wb      (unit_wb),
        .commit       (commit),
        .issue_id     (issue_id),
        .id_available (id_available),
        .queue_empty  (queue_empty)
    );

    reg_file reg_file_inst (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .rd_addr_port (reg_addr),
        .rd_data_port (reg_data)
    );

    // Anything still between accept and retire
    assign busy = ~queue_empty;

endmodule

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

////////////////////////////////////////
// Stimulus table

// First rows are hand picked, the rest come from the LFSR
localparam int NUM_FIXED = 21;
localparam int NUM_ROWS  = 42;

// One issued instruction with its expected result
typedef struct packed {
    exec_pkg::op_t       op;
    logic [`WB_XLEN-1:0] operand_a;
    logic [`WB_XLEN-1:0] operand_b;
    logic [4:0]          rd_addr;
    logic                no_rd;
    // Idle cycles after the ack
    logic [3:0]          gap;
    logic [`WB_XLEN-1:0] expected;
} vector_t;

vector_t     vectors [NUM_ROWS];
logic [31:0] lfsr_state;

////////////////////////////////////////
// Random source

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
        next = next ^ 32'h8020_0003;
    return next;
endfunction

// One step per bit taken
function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

// Expected value per operation, low word of the full product for MUL
function automatic logic [`WB_XLEN-1:0] ref_result(input exec_pkg::op_t op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
    logic [63:0] full;
    full = a * b;
    case (op)
        exec_pkg::OP_ADD: return a + b;
        exec_pkg::OP_SUB: return a - b;
        exec_pkg::OP_XOR: return a ^ b;
        default:          return full[31:0];
    endcase
endfunction

task automatic set_row(input int idx, input exec_pkg::op_t op, input logic [31:0] a,
                       input logic [31:0] b, input int rd, input int no_rd, input int gap,
                       input logic [31:0] expected);
    vectors[idx].op        = op;
    vectors[idx].operand_a = a;
    vectors[idx].operand_b = b;
    vectors[idx].rd_addr   = rd[4:0];
    vectors[idx].no_rd     = no_rd[0];
    vectors[idx].gap       = gap[3:0];
    vectors[idx].expected  = expected;
endtask

task automatic load_vectors();
    exec_pkg::op_t op;
    logic [31:0]   a;
    logic [31:0]   b;
    int            rd;
    int            no_rd;
    int            gap;
    // ALU basics
    set_row(0, exec_pkg::OP_ADD, 32'h00000005, 32'h00000007, 1, 0, 1, 32'h0000000C);
    set_row(1, exec_pkg::OP_SUB, 32'h00000064, 32'h00000001, 2, 0, 1, 32'h00000063);
    set_row(2, exec_pkg::OP_XOR, 32'hF0F0F0F0, 32'h0FF00FF0, 3, 0, 1, 32'hFF00FF00);
    set_row(3, exec_pkg::OP_SUB, 32'h00000000, 32'h00000001, 4, 0, 2, 32'hFFFFFFFF);
    // Multiplier, wrapping products too
    set_row(4, exec_pkg::OP_MUL, 32'h00000006, 32'h00000007, 5, 0, 1, 32'h0000002A);
    set_row(5, exec_pkg::OP_MUL, 32'hFFFFFFFF, 32'hFFFFFFFF, 6, 0, 1, 32'h00000001);
    set_row(6, exec_pkg::OP_MUL, 32'h00010000, 32'h00010000, 7, 0, 3, 32'h00000000);
    // MUL then ALU ops straight after, ALU finishes first
    set_row(7, exec_pkg::OP_MUL, 32'h12345678, 32'h00000009, 8, 0, 0, 32'hA3D70A38);
    set_row(8, exec_pkg::OP_ADD, 32'h00000001, 32'h00000002, 9, 0, 0, 32'h00000003);
    set_row(9, exec_pkg::OP_XOR, 32'hAAAA5555, 32'hFFFF0000, 10, 0, 0, 32'h55555555);
    // Same rd as the MUL, must land last
    set_row(10, exec_pkg::OP_SUB, 32'h0000000A, 32'h00000003, 8, 0, 2, 32'h00000007);
    // no_rd and x0 destinations
    set_row(11, exec_pkg::OP_ADD, 32'h00000001, 32'h00000001, 11, 1, 1, 32'h00000002);
    set_row(12, exec_pkg::OP_ADD, 32'h00000011, 32'h00000022, 0, 0, 1, 32'h00000033);
    set_row(13, exec_pkg::OP_MUL, 32'h00000003, 32'h00000003, 0, 0, 2, 32'h00000009);
    // Burst longer than the tag count
    set_row(14, exec_pkg::OP_MUL, 32'h0000FFFF, 32'h0000FFFF, 12, 0, 0, 32'hFFFE0001);
    set_row(15, exec_pkg::OP_MUL, 32'h80000000, 32'h00000002, 13, 0, 0, 32'h00000000);
    set_row(16, exec_pkg::OP_MUL, 32'h7FFFFFFF, 32'h00000003, 14, 0, 0, 32'h7FFFFFFD);
    set_row(17, exec_pkg::OP_MUL, 32'hDEADBEEF, 32'h00000001, 15, 0, 0, 32'hDEADBEEF);
    set_row(18, exec_pkg::OP_ADD, 32'hFFFFFFFF, 32'h00000002, 16, 0, 0, 32'h00000001);
    set_row(19, exec_pkg::OP_MUL, 32'h00010001, 32'h00010001, 17, 0, 0, 32'h00020001);
    set_row(20, exec_pkg::OP_XOR, 32'h12345678, 32'h12345678, 18, 0, 3, 32'h00000000);
    // Random second half, about one in eight has no_rd
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
        op    = exec_pkg::op_t'(rand_bits(2));
        a     = rand_bits(32);
        b     = rand_bits(32);
        rd    = rand_bits(5);
        no_rd = (rand_bits(3) == 0);
        gap   = rand_bits(2);
        set_row(r, op, a, b, rd, no_rd, gap, ref_result(op, a, b));
    end
endtask

`endif

// File: tb/tb_backend.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module tb_backend;

    // Commits we expect next in issue order
    typedef struct packed {
        logic [4:0]             rd_addr;
        core_id_pkg::instr_id_t id;
        logic [`WB_XLEN-1:0]    data;
    } exp_commit_t;

    localparam int ACK_TIMEOUT   = 100;
    localparam int DRAIN_TIMEOUT = 200;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    exec_pkg::issue_req_t    wb_dat;
    logic [4:0]              reg_addr;
    logic                    wb_ack;
    core_id_pkg::rf_commit_t commit;
    logic [`WB_XLEN-1:0]     reg_data;
    logic                    busy;

    int                     error_count;
    int                     commit_count;
    int                     expected_commits;
    int                     active_row;
    logic                   timed_out;
    // Tags come out of a wrapping counter
    core_id_pkg::instr_id_t next_tag;
    exp_commit_t            exp_queue [$];
    logic [`WB_XLEN-1:0]    reg_model [32];

    `include "tb_vectors.svh"

    wb_backend_top UUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat   (wb_dat),
        .reg_addr (reg_addr),
        .wb_ack   (wb_ack),
        .commit   (commit),
        .reg_data (reg_data),
        .busy     (busy)
    );

    // 8 ns period
    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Checking and reporting

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("Run done: %0d errors, %0d commits seen", error_count, commit_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    endtask

    ////////////////////////////////////////
    // Wishbone master

    // Hold the write until ack and drop it after the ack cycle
    task automatic issue_row(input int idx);
        int   waited;
        logic got_ack;
        waited     = 0;
        got_ack    = 1'b0;
        active_row = idx;
        wb_cyc           = 1'b1;
        wb_stb           = 1'b1;
        wb_we            = 1'b1;
        wb_dat.op        = vectors[idx].op;
        wb_dat.operand_a = vectors[idx].operand_a;
        wb_dat.operand_b = vectors[idx].operand_b;
        wb_dat.rd_addr   = vectors[idx].rd_addr;
        wb_dat.no_rd     = vectors[idx].no_rd;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            got_ack = wb_ack;
            waited++;
        end
        if (!got_ack) begin
            error_count++;
            timed_out = 1'b1;
            $display("No ack for row %0d within %0d cycles", idx, ACK_TIMEOUT);
        end else begin
            // Request is taken at the end of the ack cycle
            @(posedge clk);
            #1;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            repeat (vectors[idx].gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Until busy is low and every expected commit has shown up
    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((busy || exp_queue.size() != 0) && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy || exp_queue.size() != 0) begin
            error_count++;
            timed_out = 1'b1;
            $display("Backend did not drain, busy %b with %0d commits missing",
                     busy, exp_queue.size());
        end
    endtask

    ////////////////////////////////////////
    // Monitor

    // Mid-cycle sampling where registered outputs are settled
    always @(negedge clk) begin : monitor
        exp_commit_t entry;
        if (!rst && wb_ack && wb_cyc && wb_stb && wb_we) begin
            if (!vectors[active_row].no_rd) begin
                entry.rd_addr = vectors[active_row].rd_addr;
                entry.id      = next_tag;
                entry.data    = vectors[active_row].expected;
                exp_queue.push_back(entry);
                expected_commits++;
                if (entry.rd_addr != 5'd0)
                    reg_model[entry.rd_addr] = entry.data;
            end
            // no_rd still uses up a tag
            next_tag++;
        end
        if (!rst && commit.commit) begin
            commit_count++;
            if (exp_queue.size() == 0) begin
                error_count++;
                $display("Commit to rd_addr %0d with nothing pending", commit.rd_addr);
            end else begin
                entry = exp_queue.pop_front();
                check_value("commit.rd_addr", entry.rd_addr, commit.rd_addr);
                check_value("commit.rd_nzero", entry.rd_addr != 5'd0, commit.rd_nzero);
                check_value("commit.id", entry.id, commit.id);
                check_value("commit.rd_data", entry.data, commit.rd_data);
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence

    initial begin : main
        clk              = 1'b0;
        rst              = 1'b1;
        wb_cyc           = 1'b0;
        wb_stb           = 1'b0;
        wb_we            = 1'b0;
        wb_dat           = '0;
        reg_addr         = '0;
        error_count      = 0;
        commit_count     = 0;
        expected_commits = 0;
        active_row       = 0;
        timed_out        = 1'b0;
        next_tag         = '0;
        for (int i = 0; i < 32; i++)
            reg_model[i] = '0;
        lfsr_state = 32'd91;
        load_vectors();

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < NUM_ROWS && !timed_out; r++)
            issue_row(r);

        if (!timed_out)
            wait_drained();

        if (!timed_out) begin
            // A few quiet cycles to catch a stray commit
            repeat (4) @(posedge clk);

            // Architectural state against the model including x0
            for (int i = 0; i < 32; i++) begin
                @(posedge clk);
                #1;
                reg_addr = i[4:0];
                @(negedge clk);
                check_value($sformatf("reg_data x%0d", i), reg_model[i], reg_data);
            end
            check_value("commit count", expected_commits, commit_count);
        end
        finish_run();
    end

endmodule

// File: verilog.f
+incdir+include
+incdir+tb
hw/core_id_pkg.sv
hw/exec_pkg.sv
hw/id_tracking.sv
hw/exec_unit.sv
hw/write_back.sv
hw/reg_file.sv
hw/wb_backend_top.sv
tb/tb_backend.sv
